// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_qspi_flash_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: qspi_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_byte_engine (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic             quad_i,
    input  logic             rx_en_i,
    input  qspi_pkg::byte_u  tx_byte_i,
    input  logic [3:0]       io_i,
    output qspi_pkg::byte_u  rx_byte_o,
    output logic             byte_done_o,
    output logic             sck_o,
    output logic [3:0]       io_o,
    output logic [3:0]       io_oe_o
);

    logic            active;
    // high half of an sck period
    logic            phase;
    logic [2:0]      step;
    logic            quad_q;
    logic            rx_en_q;
    logic            last_step;
    qspi_pkg::byte_u tx_q;
    qspi_pkg::byte_u rx_q;

    // 8 sck periods per byte in SPI, 2 in QPI
    assign last_step = quad_q ? (step == 3'd1) : (step == 3'd7);

    // last high half of the byte, rx_q already holds the full byte
    assign byte_done_o = active & phase & last_step;

    // phase is only ever set while active, so sck idles low
    assign sck_o     = phase;
    assign rx_byte_o = rx_q;

    // SPI drives io0 only, QPI presents the high nibble first
    assign io_o = quad_q ? tx_q.nib.hi : {3'b000, tx_q.bits[7]};

    always_comb begin
        if (!active) begin
            io_oe_o = 4'b0000;
        end else if (quad_q) begin
            // quad data bytes turn the bus around to the flash
            io_oe_o = rx_en_q ? 4'b0000 : 4'b1111;
        end else begin
            io_oe_o = 4'b0001;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active  <= 1'b0;
            phase   <= 1'b0;
            step    <= 3'd0;
            quad_q  <= 1'b0;
            rx_en_q <= 1'b0;
        end else if (!active) begin
            phase <= 1'b0;
            if (start_i) begin
                active  <= 1'b1;
                step    <= 3'd0;
                quad_q  <= quad_i;
                rx_en_q <= rx_en_i;
            end
        end else begin
            phase <= ~phase;
            // a period ends when sck falls
            if (phase) begin
                if (last_step) begin
                    active <= 1'b0;
                end else begin
                    step <= step + 3'd1;
                end
            end
        end
    end

    // transmit shifter, new data appears while sck is low
    always_ff @(posedge clk_i) begin
        if (!active && start_i) begin
            tx_q <= tx_byte_i;
        end else if (active && phase) begin
            if (quad_q) begin
                tx_q.bits <= {tx_q.bits[3:0], 4'h0};
            end else begin
                tx_q.bits <= {tx_q.bits[6:0], 1'b0};
            end
        end
    end

    // receive shifter, sampled on the edge that raises sck
    always_ff @(posedge clk_i) begin
        if (active && !phase) begin
            if (quad_q) begin
                rx_q.nib.hi <= rx_q.nib.lo;
                rx_q.nib.lo <= io_i;
            end else begin
                rx_q.bits <= {rx_q.bits[6:0], io_i[1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: qspi_defines.svh
`ifndef QSPI_DEFINES_SVH
`define QSPI_DEFINES_SVH

// single-line read, no dummy cycles
`define QSPI_CMD_READ      8'h03
// quad read, one dummy byte after the address
`define QSPI_CMD_FAST_READ 8'h0B

// flash address, sent as three bytes
`define QSPI_ADDR_W        24
// byte count of one read, 0 stands for 256
`define QSPI_LEN_W         8

`endif

// File: qspi_flash_top.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_flash_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  qspi_pkg::read_req_t req_data_i,
    input  qspi_pkg::pins_i_t   pins_i,
    output qspi_pkg::pins_o_t   pins_o,
    output qspi_pkg::byte_u     rdata_o,
    output logic                rvalid_o,
    output logic                done_o,
    output logic                busy_o
);

    logic            start;
    logic            quad;
    logic            rx_en;
    logic            byte_done;
    logic            cs_n;
    logic            sck;
    logic [3:0]      io_out;
    logic [3:0]      io_oe;
    qspi_pkg::byte_u tx_byte;
    qspi_pkg::byte_u rx_byte;

    qspi_read_seq i_read_seq (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .byte_done_i (byte_done),
        .rx_byte_i   (rx_byte),
        .start_o     (start),
        .quad_o      (quad),
        .rx_en_o     (rx_en),
        .tx_byte_o   (tx_byte),
        .cs_n_o      (cs_n),
        .rdata_o     (rdata_o),
        .rvalid_o    (rvalid_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    qspi_byte_engine i_byte_engine (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (start),
        .quad_i      (quad),
        .rx_en_i     (rx_en),
        .tx_byte_i   (tx_byte),
        .io_i        (pins_i.io),
        .rx_byte_o   (rx_byte),
        .byte_done_o (byte_done),
        .sck_o       (sck),
        .io_o        (io_out),
        .io_oe_o     (io_oe)
    );

    // chip select from the sequencer, clock and data lines from the engine
    assign pins_o.cs_n  = cs_n;
    assign pins_o.sck   = sck;
    assign pins_o.io    = io_out;
    assign pins_o.io_oe = io_oe;

endmodule

`default_nettype wire

// File: qspi_pkg.sv
`default_nettype none

`include "qspi_defines.svh"

package qspi_pkg;

    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } nib_t;

    // one wire byte: bit view for SPI, nibble view for QPI
    typedef union packed {
        logic [7:0] bits;
        nib_t       nib;
    } byte_u;

    typedef struct packed {
        logic [`QSPI_ADDR_W-1:0] addr;
        logic [`QSPI_LEN_W-1:0]  len;
        logic                    quad;
    } read_req_t;

    // reader side of the flash pins
    typedef struct packed {
        logic       cs_n;
        logic       sck;
        logic [3:0] io;
        logic [3:0] io_oe;
    } pins_o_t;

    typedef struct packed {
        logic [3:0] io;
    } pins_i_t;

endpackage

`default_nettype wire

// File: qspi_read_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "qspi_defines.svh"

module qspi_read_seq (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  qspi_pkg::read_req_t req_data_i,
    input  logic                byte_done_i,
    input  qspi_pkg::byte_u     rx_byte_i,
    output logic                start_o,
    output logic                quad_o,
    output logic                rx_en_o,
    output qspi_pkg::byte_u     tx_byte_o,
    output logic                cs_n_o,
    output qspi_pkg::byte_u     rdata_o,
    output logic                rvalid_o,
    output logic                done_o,
    output logic                busy_o
);

    localparam int ADDR_BYTES = `QSPI_ADDR_W / 8;

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_CMD   = 3'd1;
    localparam logic [2:0] ST_ADDR  = 3'd2;
    localparam logic [2:0] ST_DUMMY = 3'd3;
    localparam logic [2:0] ST_DATA  = 3'd4;

    logic [2:0]              state;
    logic [1:0]              idx;
    logic [`QSPI_LEN_W-1:0]  remaining;
    logic [`QSPI_ADDR_W-1:0] addr_q;
    logic                    quad_q;
    logic                    cs_n_q;
    logic                    start_q;
    logic                    rvalid_q;
    logic                    done_q;
    qspi_pkg::byte_u         rdata_q;

    assign busy_o   = (state != ST_IDLE);
    assign start_o  = start_q;
    assign quad_o   = quad_q;
    assign rx_en_o  = (state == ST_DATA);
    assign cs_n_o   = cs_n_q;
    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;
    assign done_o   = done_q;

    // byte presented to the engine for the current phase
    always_comb begin
        case (state)
            ST_CMD:  tx_byte_o.bits = quad_q ? `QSPI_CMD_FAST_READ : `QSPI_CMD_READ;
            // address goes out most significant byte first
            ST_ADDR: tx_byte_o.bits = addr_q[(`QSPI_ADDR_W - 1) - 8 * idx -: 8];
            default: tx_byte_o.bits = 8'h00;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= ST_IDLE;
            idx       <= 2'd0;
            remaining <= '0;
            quad_q    <= 1'b0;
            cs_n_q    <= 1'b1;
            start_q   <= 1'b0;
            rvalid_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            start_q  <= 1'b0;
            rvalid_q <= 1'b0;
            done_q   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_i) begin
                        state     <= ST_CMD;
                        remaining <= req_data_i.len;
                        quad_q    <= req_data_i.quad;
                        cs_n_q    <= 1'b0;
                        start_q   <= 1'b1;
                    end
                end
                ST_CMD: begin
                    if (byte_done_i) begin
                        state   <= ST_ADDR;
                        idx     <= 2'd0;
                        start_q <= 1'b1;
                    end
                end
                ST_ADDR: begin
                    if (byte_done_i) begin
                        start_q <= 1'b1;
                        if (idx == 2'(ADDR_BYTES - 1)) begin
                            // dummy byte only for the quad read
                            state <= quad_q ? ST_DUMMY : ST_DATA;
                        end else begin
                            idx <= idx + 2'd1;
                        end
                    end
                end
                ST_DUMMY: begin
                    if (byte_done_i) begin
                        state   <= ST_DATA;
                        start_q <= 1'b1;
                    end
                end
                ST_DATA: begin
                    if (byte_done_i) begin
                        rvalid_q  <= 1'b1;
                        remaining <= remaining - 1'b1;
                        // len of 0 wraps through 255 and gives 256 bytes
                        if (remaining == `QSPI_LEN_W'(1)) begin
                            state  <= ST_IDLE;
                            cs_n_q <= 1'b1;
                            done_q <= 1'b1;
                        end else begin
                            start_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    state  <= ST_IDLE;
                    cs_n_q <= 1'b1;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        if (state == ST_IDLE && req_i) begin
            addr_q <= req_data_i.addr;
        end
        if (state == ST_DATA && byte_done_i) begin
            rdata_q <= rx_byte_i;
        end
    end

endmodule

`default_nettype wire

// File: tb_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "qspi_defines.svh"

module tb_flash_model (
    input  qspi_pkg::pins_o_t       pins_o_i,
    input  logic                    quad_i,
    output qspi_pkg::pins_i_t       pins_i_o,
    output logic [`QSPI_ADDR_W-1:0] addr_o,
    output logic                    err_o
);

    logic [7:0]              in_sh;
    logic [7:0]              out_sh;
    logic [3:0]              drive;
    logic [3:0]              exp_oe;
    logic [`QSPI_ADDR_W-1:0] rd_addr;
    logic                    data_ph;
    int                      in_cnt;
    int                      out_cnt;
    int                      byte_idx;

    // stored content, derived from the byte address
    function automatic logic [7:0] pattern(input logic [`QSPI_ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // undriven lines read as pulled high
    assign pins_i_o.io = drive;

    initial begin
        in_cnt   = 0;
        out_cnt  = 0;
        byte_idx = 0;
        data_ph  = 1'b0;
        drive    = 4'hF;
        exp_oe   = 4'h0;
        rd_addr  = '0;
        addr_o   = '0;
        err_o    = 1'b0;
    end

    // end of a transaction
    always @(posedge pins_o_i.cs_n) begin
        in_cnt   = 0;
        byte_idx = 0;
        data_ph  = 1'b0;
        drive    = 4'hF;
    end

    always @(posedge pins_o_i.sck) begin
        if (!pins_o_i.cs_n) begin
            // SPI drives io0 only, quad data turns the bus around
            if (!quad_i) begin
                exp_oe = 4'b0001;
            end else if (data_ph) begin
                exp_oe = 4'b0000;
            end else begin
                exp_oe = 4'b1111;
            end
            if (pins_o_i.io_oe !== exp_oe) begin
                $display("flash model: reader enables were %b where %b belongs",
                         pins_o_i.io_oe, exp_oe);
                err_o = 1'b1;
            end
            if (!data_ph) begin
                if (quad_i) begin
                    in_sh  = {in_sh[3:0], pins_o_i.io};
                    in_cnt = in_cnt + 4;
                end else begin
                    in_sh  = {in_sh[6:0], pins_o_i.io[0]};
                    in_cnt = in_cnt + 1;
                end
                if (in_cnt == 8) begin
                    in_cnt = 0;
                    if (byte_idx == 0) begin
                        if (in_sh !== (quad_i ? `QSPI_CMD_FAST_READ : `QSPI_CMD_READ)) begin
                            $display("flash model: wrong command byte %h for the mode", in_sh);
                            err_o = 1'b1;
                        end
                    end else if (byte_idx <= 3) begin
                        rd_addr = {rd_addr[15:0], in_sh};
                    end
                    byte_idx = byte_idx + 1;
                    // dummy byte is skipped in quad mode
                    if (byte_idx == (quad_i ? 5 : 4)) begin
                        data_ph = 1'b1;
                        addr_o  = rd_addr;
                        out_sh  = pattern(rd_addr);
                        out_cnt = 0;
                    end
                end
            end
        end
    end

    // outputs change on the falling sck edge
    always @(negedge pins_o_i.sck) begin
        if (!pins_o_i.cs_n && data_ph) begin
            if (quad_i) begin
                drive   = out_sh[7:4];
                out_sh  = {out_sh[3:0], 4'h0};
                out_cnt = out_cnt + 4;
            end else begin
                drive   = {2'b11, out_sh[7], 1'b1};
                out_sh  = {out_sh[6:0], 1'b0};
                out_cnt = out_cnt + 1;
            end
            if (out_cnt == 8) begin
                rd_addr = rd_addr + 1'b1;
                out_sh  = pattern(rd_addr);
                out_cnt = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_qspi_flash_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "qspi_defines.svh"

module tb_qspi_flash_top;

    logic                    clk;
    logic                    rst_n;
    logic                    req;
    qspi_pkg::read_req_t     req_data;
    qspi_pkg::pins_i_t       pins_i;
    qspi_pkg::pins_o_t       pins_o;
    qspi_pkg::byte_u         rdata;
    logic                    rvalid;
    logic                    done;
    logic                    busy;
    logic                    model_quad;
    logic [`QSPI_ADDR_W-1:0] model_addr;
    logic                    model_err;
    logic [`QSPI_ADDR_W-1:0] exp_addr;
    integer                  seed;
    int                      rx_count;
    int                      done_count;
    string                   test_name;

    qspi_flash_top i_qspi_flash_top (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .req_i      (req),
        .req_data_i (req_data),
        .pins_i     (pins_i),
        .pins_o     (pins_o),
        .rdata_o    (rdata),
        .rvalid_o   (rvalid),
        .done_o     (done),
        .busy_o     (busy)
    );

    tb_flash_model i_flash_model (
        .pins_o_i (pins_o),
        .quad_i   (model_quad),
        .pins_i_o (pins_i),
        .addr_o   (model_addr),
        .err_o    (model_err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected flash content at a byte address
    function automatic qspi_pkg::byte_u ref_byte(input logic [`QSPI_ADDR_W-1:0] a);
        qspi_pkg::byte_u b;
        b.bits = a[7:0] ^ a[15:8] ^ 8'h5A;
        return b;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input qspi_pkg::byte_u exp,
                              input qspi_pkg::byte_u act);
        if (act !== exp)
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp.bits, act.bits));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp)
            stop_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_addr(input string name, input logic [`QSPI_ADDR_W-1:0] exp,
                              input logic [`QSPI_ADDR_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_pins(input string name, input qspi_pkg::pins_o_t exp,
                              input qspi_pkg::pins_o_t act);
        if (act !== exp)
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    endtask

    // compares every delivered byte and counts done pulses
    always @(posedge clk) begin
        if (rst_n) begin
            if (rvalid) begin
                check_byte(test_name, ref_byte(exp_addr + rx_count[`QSPI_ADDR_W-1:0]), rdata);
                rx_count++;
            end
            if (done) begin
                // chip select rises together with done
                check_flag(test_name, 1'b1, pins_o.cs_n);
                done_count++;
            end
        end
    end

    always @(posedge model_err) begin
        stop_run("flash model saw a bad transfer");
    end

    task automatic start_read(input logic [`QSPI_ADDR_W-1:0] addr,
                              input logic [`QSPI_LEN_W-1:0] len, input logic quad);
        @(posedge clk);
        #1;
        req           = 1'b1;
        req_data.addr = addr;
        req_data.len  = len;
        req_data.quad = quad;
        model_quad    = quad;
        exp_addr      = addr;
        rx_count      = 0;
        done_count    = 0;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (done_count == 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > limit)
                stop_run("timeout while waiting for done_o");
        end
    endtask

    task automatic run_read(input string name, input logic [`QSPI_ADDR_W-1:0] addr,
                            input logic [`QSPI_LEN_W-1:0] len, input logic quad);
        test_name = name;
        start_read(addr, len, quad);
        wait_done(6000);
        check_count(name, (len == 0) ? 256 : int'(len), rx_count);
        check_addr(name, addr, model_addr);
    endtask

    initial begin
        qspi_pkg::pins_o_t        idle_pins;
        qspi_pkg::pins_o_t        seen_pins;
        logic [`QSPI_ADDR_W-1:0]  r_addr;
        logic [`QSPI_LEN_W-1:0]   r_len;
        logic                     r_quad;
        req        = 1'b0;
        req_data   = '0;
        model_quad = 1'b0;
        exp_addr   = '0;
        rx_count   = 0;
        done_count = 0;
        seed       = 45;
        test_name  = "reset";
        rst_n      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // io lines carry no defined value before the first byte
        idle_pins      = '0;
        idle_pins.cs_n = 1'b1;
        seen_pins      = pins_o;
        seen_pins.io   = '0;
        check_pins("reset pins", idle_pins, seen_pins);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset rvalid", 1'b0, rvalid);
        check_flag("reset done", 1'b0, done);

        run_read("spi read", 24'h012345, 8'd5, 1'b0);
        run_read("qpi read", 24'hABCDEF, 8'd7, 1'b1);

        for (int i = 0; i < 20; i++) begin
            r_addr = `QSPI_ADDR_W'($random(seed));
            r_len  = 8'(($random(seed) & 15) + 1);
            r_quad = 1'($random(seed) & 1);
            run_read($sformatf("random read %0d", i), r_addr, r_len, r_quad);
        end

        // second strobe lands in the middle of the first transfer
        test_name = "request while busy";
        start_read(24'h000440, 8'd4, 1'b0);
        repeat (3) @(posedge clk);
        #1;
        check_flag(test_name, 1'b1, busy);
        req           = 1'b1;
        req_data.addr = 24'h777777;
        req_data.len  = 8'd9;
        @(posedge clk);
        #1;
        req = 1'b0;
        wait_done(6000);
        repeat (40) @(posedge clk);
        #1;
        check_count(test_name, 1, done_count);
        check_count(test_name, 4, rx_count);
        check_flag(test_name, 1'b0, busy);

        run_read("length zero", 24'h0012F0, 8'd0, 1'b0);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
qspi_pkg.sv
qspi_byte_engine.sv
qspi_read_seq.sv
qspi_flash_top.sv
tb_flash_model.sv
tb_qspi_flash_top.sv
